//--- tb.f
design/rv_pkg.sv
design/rv_bus_arbiter.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_memaccess.sv
design/rv_core.sv
verification/tb_rv_mem.sv
verification/rv_core_sva.sv
verification/tb_rv_core.sv

//--- run_sim.sh
#!/bin/bash
# Build the core testbench with Verilator and run it.
# A failing run ends in $fatal, which gives a non-zero exit status.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f tb.f --top-module tb_rv_core -o sim_tb_rv_core

./obj_dir/sim_tb_rv_core

//--- verification/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;

    logic        i_clk = 1'b0;
    logic        i_rst, load_en;
    logic [31:0] max_delay, load_addr, load_data;
    logic        bus_stb, bus_we, bus_ack;
    logic [31:0] bus_addr, bus_wdata, bus_rdata;

    // stimulus table, one program per row
    logic [31:0] pre_addr [0:5][0:15];         // preload words, program and data
    logic [31:0] pre_data [0:5][0:15];
    int          n_pre [0:5];
    logic [31:0] exp_addr [0:5][0:5];          // expected stores, in order
    logic [31:0] exp_data [0:5][0:5];
    int          n_exp [0:5];
    logic [31:0] row_delay [0:5];
    int          cur;                          // row being built

    always #2 i_clk = ~i_clk;                  // 4 ns period

    rv_core rv_core_i (
        .i_clk(i_clk), .i_rst(i_rst),
        .o_bus_stb(bus_stb), .o_bus_we(bus_we), .o_bus_addr(bus_addr),
        .o_bus_wdata(bus_wdata), .i_bus_rdata(bus_rdata), .i_bus_ack(bus_ack)
    );

    tb_rv_mem mem_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_max_delay(max_delay),
        .i_load_en(load_en), .i_load_addr(load_addr), .i_load_data(load_data),
        .i_stb(bus_stb), .i_we(bus_we), .i_addr(bus_addr), .i_wdata(bus_wdata),
        .o_rdata(bus_rdata), .o_ack(bus_ack)
    );

    bind rv_core rv_core_sva sva_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_bus_stb(o_bus_stb), .i_bus_we(o_bus_we),
        .i_bus_addr(o_bus_addr), .i_bus_wdata(o_bus_wdata), .i_bus_ack(i_bus_ack)
    );

    // rv32i encoders
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // sw
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic preload(logic [31:0] a, logic [31:0] d);
        pre_addr[cur][n_pre[cur]] = a;
        pre_data[cur][n_pre[cur]] = d;
        n_pre[cur] = n_pre[cur] + 1;
    endtask

    task automatic expect_store(logic [31:0] a, logic [31:0] d);
        exp_addr[cur][n_exp[cur]] = a;
        exp_data[cur][n_exp[cur]] = d;
        n_exp[cur] = n_exp[cur] + 1;
    endtask

    task automatic build_table();
        for (int r = 0; r < 6; r++) begin
            n_pre[r] = 0;
            n_exp[r] = 0;
        end
        cur = 0;                               // alu ops, dependent chains
        preload(32'h00, {20'h12345, 5'd1, 7'b0110111});                 // lui x1
        preload(32'h04, enc_i(32'h123, 5'd1, 3'b000, 5'd2, 7'b0010011)); // addi x2,x1
        preload(32'h08, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));        // add x3
        preload(32'h0c, enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));        // sub x4
        preload(32'h10, enc_r(7'h00, 5'd3, 5'd1, 3'b100, 5'd5));        // xor x5
        preload(32'h14, enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));        // or x6
        preload(32'h18, enc_r(7'h00, 5'd2, 5'd3, 3'b111, 5'd7));        // and x7
        preload(32'h1c, enc_i(32'hfff, 5'd0, 3'b000, 5'd8, 7'b0010011)); // addi x8,-1
        for (int k = 0; k < 6; k++)
            preload(32'h20 + 4 * k, enc_s(32'h100 + 4 * k, 5'(k + 3), 5'd0));
        preload(32'h38, enc_j(32'h0, 5'd0));                             // park loop
        expect_store(32'h100, 32'h2468_a123);
        expect_store(32'h104, 32'h1234_5000);
        expect_store(32'h108, 32'h365c_f123);
        expect_store(32'h10c, 32'h1234_5123);
        expect_store(32'h110, 32'h0020_0123);
        expect_store(32'h114, 32'hffff_ffff);
        cur = 1;                               // load-use
        preload(32'h00, enc_i(32'h200, 5'd0, 3'b010, 5'd1, 7'b0000011)); // lw x1
        preload(32'h04, enc_i(32'h5, 5'd1, 3'b000, 5'd2, 7'b0010011));   // addi x2,x1,5
        preload(32'h08, enc_s(32'h120, 5'd2, 5'd0));
        preload(32'h0c, enc_i(32'h204, 5'd0, 3'b010, 5'd3, 7'b0000011)); // lw x3
        preload(32'h10, enc_r(7'h00, 5'd3, 5'd3, 3'b000, 5'd4));        // add x4,x3,x3
        preload(32'h14, enc_s(32'h124, 5'd4, 5'd0));
        preload(32'h18, enc_j(32'h0, 5'd0));
        preload(32'h200, 32'h1357_9bdf);
        preload(32'h204, 32'h0246_8ace);
        expect_store(32'h120, 32'h1357_9be4);
        expect_store(32'h124, 32'h048d_159c);
        cur = 2;                               // branches and jal
        preload(32'h00, enc_i(32'h7, 5'd0, 3'b000, 5'd1, 7'b0010011));
        preload(32'h04, enc_i(32'h7, 5'd0, 3'b000, 5'd2, 7'b0010011));
        preload(32'h08, enc_b(32'h8, 5'd2, 5'd1, 3'b000));              // beq taken
        preload(32'h0c, enc_s(32'h130, 5'd1, 5'd0));                    // skipped
        preload(32'h10, enc_b(32'h8, 5'd2, 5'd1, 3'b001));              // bne not taken
        preload(32'h14, enc_s(32'h134, 5'd2, 5'd0));
        preload(32'h18, enc_b(32'h8, 5'd0, 5'd1, 3'b001));              // bne taken
        preload(32'h1c, enc_s(32'h138, 5'd1, 5'd0));                    // skipped
        preload(32'h20, enc_b(32'h8, 5'd0, 5'd1, 3'b000));              // beq not taken
        preload(32'h24, enc_j(32'h8, 5'd5));                            // jal x5
        preload(32'h28, enc_s(32'h13c, 5'd1, 5'd0));                    // skipped
        preload(32'h2c, enc_s(32'h140, 5'd5, 5'd0));                    // link value
        preload(32'h30, enc_j(32'h0, 5'd0));
        expect_store(32'h134, 32'h0000_0007);
        expect_store(32'h140, 32'h0000_0028);
        for (int r = 0; r < 3; r++) begin      // same programs, slow bus
            row_delay[r]     = 32'd0;
            row_delay[r + 3] = 32'd5;
            n_pre[r + 3]     = n_pre[r];
            n_exp[r + 3]     = n_exp[r];
            pre_addr[r + 3]  = pre_addr[r];
            pre_data[r + 3]  = pre_data[r];
            exp_addr[r + 3]  = exp_addr[r];
            exp_data[r + 3]  = exp_data[r];
        end
    endtask

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic run_row(int r);
        @(posedge i_clk);
        #1;
        i_rst     = 1'b1;
        max_delay = row_delay[r];
        for (int k = 0; k < 16; k++) begin     // preload during the 16 reset cycles
            load_en   = (k < n_pre[r]);
            load_addr = pre_addr[r][k];
            load_data = pre_data[r][k];
            @(posedge i_clk);
            #1;
        end
        load_en = 1'b0;
        i_rst   = 1'b0;
        while (mem_i.log_n < n_exp[r])
            @(posedge i_clk);
        for (int k = 0; k < n_exp[r]; k++) begin
            assert (mem_i.log_addr[k] == exp_addr[r][k] && mem_i.log_data[k] == exp_data[r][k])
            else stop_on_error($sformatf(
                "CHECK FAILED t=%0t row %0d store %0d got %h<=%h exp %h<=%h", $time, r, k,
                mem_i.log_addr[k], mem_i.log_data[k], exp_addr[r][k], exp_data[r][k]));
        end
        repeat (50) @(posedge i_clk);          // late extra stores would show here
        assert (mem_i.log_n == n_exp[r])
        else stop_on_error($sformatf("CHECK FAILED t=%0t row %0d store count %0d exp %0d",
                                     $time, r, mem_i.log_n, n_exp[r]));
    endtask

    initial begin
        i_rst     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        max_delay = '0;
        build_table();
        for (int r = 0; r < 6; r++)
            run_row(r);
        $display("Done: no errors");
        $finish;
    end

    // watchdog, budget from table delays
    initial begin
        int limit;
        #1;
        limit = 0;
        for (int r = 0; r < 6; r++)
            limit = limit + 200 * (row_delay[r] + 1) + 16 + 51;
        #(limit * 4);
        stop_on_error("Watchdog timeout: expected stores never completed");
    end

endmodule

//--- verification/rv_core_sva.sv
`timescale 1ns/1ns

module rv_core_sva (
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_bus_stb,
    input logic        i_bus_we,
    input logic [31:0] i_bus_addr,
    input logic [31:0] i_bus_wdata,
    input logic        i_bus_ack
);

    // request held with the same address and data until its ack
    a_stb_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_bus_stb && !i_bus_ack) |=> (i_bus_stb && $stable(i_bus_addr) &&
                                       $stable(i_bus_we) && $stable(i_bus_wdata)))
        else $error("bus request changed before its ack");

    // no write enable without a strobe
    a_we_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_bus_stb |-> !i_bus_we)
        else $error("write enable high while strobe low");

    // first cycle out of reset is idle
    a_stb_after_rst: assert property (@(posedge i_clk)
        $fell(i_rst) |-> !i_bus_stb)
        else $error("strobe high in first cycle after reset");

endmodule

//--- verification/tb_rv_mem.sv
`timescale 1ns/1ns

module tb_rv_mem (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [31:0] i_max_delay,           // upper bound of random ack wait
    input  logic        i_load_en,             // preload port, used during reset
    input  logic [31:0] i_load_addr,
    input  logic [31:0] i_load_data,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_wdata,
    output logic [31:0] o_rdata,
    output logic        o_ack
);

    logic [31:0] mem [0:255];                  // 1 KiB, word addressed by addr[9:2]
    logic [31:0] log_addr [0:15];              // store log, in bus order
    logic [31:0] log_data [0:15];
    int          log_n;
    integer      seed = 32'hd8770132;
    logic        busy;                         // transfer accepted, ack pending
    int          cnt;
    logic        stb_s, we_s;
    logic [31:0] addr_s, wdata_s;
    logic        rst_s, load_en_s;
    logic [31:0] load_addr_s, load_data_s, max_delay_s;

    initial begin
        o_ack   = 1'b0;
        o_rdata = '0;
        busy    = 1'b0;
        cnt     = 0;
        log_n   = 0;
    end

    always begin
        @(posedge i_clk);
        stb_s       = i_stb;                   // values seen at the edge
        we_s        = i_we;
        addr_s      = i_addr;
        wdata_s     = i_wdata;
        rst_s       = i_rst;                   // same edge the core resets on
        load_en_s   = i_load_en;
        load_addr_s = i_load_addr;
        load_data_s = i_load_data;
        max_delay_s = i_max_delay;
        #1;
        if (rst_s) begin
            o_ack = 1'b0;
            busy  = 1'b0;
            log_n = 0;                         // fresh log per program
            if (load_en_s)
                mem[load_addr_s[9:2]] = load_data_s;
        end else if (o_ack) begin
            o_ack = 1'b0;                      // single-cycle ack, transfer done
            busy  = 1'b0;
        end else if (stb_s) begin
            if (!busy) begin
                busy = 1'b1;
                cnt  = $unsigned($random(seed)) % (max_delay_s + 32'd1);
            end
            if (cnt == 0) begin
                o_ack   = 1'b1;
                o_rdata = mem[addr_s[9:2]];    // read data valid in ack cycle
                if (we_s) begin
                    mem[addr_s[9:2]] = wdata_s;
                    if (log_n < 16) begin
                        log_addr[log_n] = addr_s;
                        log_data[log_n] = wdata_s;
                    end
                    log_n = log_n + 1;         // counts past 16 so overflow shows
                end
            end else begin
                cnt = cnt - 1;
            end
        end
    end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    output logic            o_bus_stb,
    output logic            o_bus_we,
    output logic [xlen-1:0] o_bus_addr,
    output logic [xlen-1:0] o_bus_wdata,
    input  logic [xlen-1:0] i_bus_rdata,
    input  logic            i_bus_ack
);

    // fetch side
    logic                  if_stb, if_ack, fetch_valid;
    logic [xlen-1:0]       if_addr, fetch_pc, bus_rdata;
    inst_u                 fetch_inst;

    // execute side
    logic                  flush, ex_valid, ex_load, ex_store, ex_rd_wr;
    logic [xlen-1:0]       target_pc, ex_result, ex_store_data, rs1_data, rs2_data;
    logic [reg_addr_w-1:0] rs1_addr, rs2_addr, ex_rd_addr;

    // memory/writeback side
    logic                  dm_stb, dm_we, dm_ack, busy, wb_en;
    logic [xlen-1:0]       dm_addr, dm_wdata, wb_data;
    logic [reg_addr_w-1:0] wb_addr;

    rv_fetch u_fetch (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_stall(busy), .i_flush(flush), .i_target_pc(target_pc),  // redirect from execute
        .o_if_stb(if_stb), .o_if_addr(if_addr), .i_if_ack(if_ack), .i_rdata(bus_rdata),
        .o_inst(fetch_inst), .o_pc(fetch_pc), .o_valid(fetch_valid)
    );

    rv_execute u_execute (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_inst(fetch_inst), .i_pc(fetch_pc), .i_valid(fetch_valid), .i_stall(busy),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .i_fwd_wr(wb_en), .i_fwd_addr(wb_addr), .i_fwd_data(wb_data),  // bypass path
        .o_flush(flush), .o_target_pc(target_pc),
        .o_valid(ex_valid), .o_is_load(ex_load), .o_is_store(ex_store),
        .o_rd_wr(ex_rd_wr), .o_rd_addr(ex_rd_addr),
        .o_result(ex_result), .o_store_data(ex_store_data)
    );

    rv_memaccess u_memaccess (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_valid(ex_valid), .i_is_load(ex_load), .i_is_store(ex_store),
        .i_rd_wr(ex_rd_wr), .i_rd_addr(ex_rd_addr),
        .i_result(ex_result), .i_store_data(ex_store_data),
        .o_dm_stb(dm_stb), .o_dm_we(dm_we), .o_dm_addr(dm_addr), .o_dm_wdata(dm_wdata),
        .i_dm_ack(dm_ack), .i_rdata(bus_rdata),
        .o_busy(busy),
        .o_wr_en(wb_en), .o_wr_addr(wb_addr), .o_wr_data(wb_data)
    );

    rv_regfile u_regfile (
        .i_clk(i_clk),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_wr_en(wb_en), .i_rd_addr(wb_addr), .i_rd_data(wb_data)
    );

    rv_bus_arbiter u_arbiter (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_if_stb(if_stb), .i_if_addr(if_addr), .o_if_ack(if_ack),
        .i_dm_stb(dm_stb), .i_dm_we(dm_we), .i_dm_addr(dm_addr), .i_dm_wdata(dm_wdata),
        .o_dm_ack(dm_ack), .o_rdata(bus_rdata),
        .o_bus_stb(o_bus_stb), .o_bus_we(o_bus_we),
        .o_bus_addr(o_bus_addr), .o_bus_wdata(o_bus_wdata),
        .i_bus_rdata(i_bus_rdata), .i_bus_ack(i_bus_ack)
    );

endmodule

//--- design/rv_memaccess.sv
`timescale 1ns/1ns

module rv_memaccess import rv_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  logic                  i_is_load,
    input  logic                  i_is_store,
    input  logic                  i_rd_wr,
    input  logic [reg_addr_w-1:0] i_rd_addr,
    input  logic [xlen-1:0]       i_result,
    input  logic [xlen-1:0]       i_store_data,
    output logic                  o_dm_stb,
    output logic                  o_dm_we,
    output logic [xlen-1:0]       o_dm_addr,
    output logic [xlen-1:0]       o_dm_wdata,
    input  logic                  i_dm_ack,
    input  logic [xlen-1:0]       i_rdata,
    output logic                  o_busy,          // stalls fetch and execute
    output logic                  o_wr_en,         // regfile write, also forwarded
    output logic [reg_addr_w-1:0] o_wr_addr,
    output logic [xlen-1:0]       o_wr_data
);

    logic                  valid_q, load_q, store_q, rd_wr_q;
    logic [reg_addr_w-1:0] rd_addr_q;
    logic [xlen-1:0]       result_q, store_data_q;

    // stage register, held while a transfer waits
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
            load_q  <= 1'b0;
            store_q <= 1'b0;
            rd_wr_q <= 1'b0;
        end else if (!o_busy) begin
            valid_q <= i_valid;
            load_q  <= i_is_load;
            store_q <= i_is_store;
            rd_wr_q <= i_rd_wr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!o_busy) begin
            rd_addr_q    <= i_rd_addr;
            result_q     <= i_result;
            store_data_q <= i_store_data;
        end
    end

    assign o_dm_stb   = valid_q && (load_q || store_q);  // one transfer per load/store
    assign o_dm_we    = valid_q && store_q;
    assign o_dm_addr  = result_q;                        // stable until ack
    assign o_dm_wdata = store_data_q;
    assign o_busy     = o_dm_stb && !i_dm_ack;           // ack cycle frees the stage

    assign o_wr_en   = valid_q && rd_wr_q && !o_busy;
    assign o_wr_addr = rd_addr_q;
    assign o_wr_data = load_q ? i_rdata : result_q;      // load word valid in ack cycle

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  inst_u                 i_inst,
    input  logic [xlen-1:0]       i_pc,
    input  logic                  i_valid,
    input  logic                  i_stall,
    output logic [reg_addr_w-1:0] o_rs1_addr,
    output logic [reg_addr_w-1:0] o_rs2_addr,
    input  logic [xlen-1:0]       i_rs1_data,
    input  logic [xlen-1:0]       i_rs2_data,
    input  logic                  i_fwd_wr,        // mem/wb writing this cycle
    input  logic [reg_addr_w-1:0] i_fwd_addr,
    input  logic [xlen-1:0]       i_fwd_data,
    output logic                  o_flush,
    output logic [xlen-1:0]       o_target_pc,
    output logic                  o_valid,
    output logic                  o_is_load,
    output logic                  o_is_store,
    output logic                  o_rd_wr,
    output logic [reg_addr_w-1:0] o_rd_addr,
    output logic [xlen-1:0]       o_result,        // alu value, load/store address or link
    output logic [xlen-1:0]       o_store_data
);

    logic [xlen-1:0] rs1_val, rs2_val, opb, alu_y;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t         alu_op;
    logic            wr, is_load, is_store, is_br, is_jal, taken;

    assign o_rs1_addr = i_inst.r.rs1;
    assign o_rs2_addr = i_inst.r.rs2;

    // bypass from mem/wb, x0 never forwarded
    assign rs1_val = (i_fwd_wr && i_fwd_addr != '0 && i_fwd_addr == o_rs1_addr)
                     ? i_fwd_data : i_rs1_data;
    assign rs2_val = (i_fwd_wr && i_fwd_addr != '0 && i_fwd_addr == o_rs2_addr)
                     ? i_fwd_data : i_rs2_data;

    // immediates through the three views
    assign imm_i = {{20{i_inst.i.imm12[11]}}, i_inst.i.imm12};
    assign imm_s = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
    assign imm_b = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_lo[0], i_inst.s.imm_hi[5:0],
                    i_inst.s.imm_lo[4:1], 1'b0};
    assign imm_u = {i_inst.i.imm12, i_inst.i.rs1, i_inst.i.funct3, 12'b0};
    assign imm_j = {{12{i_inst.i.imm12[11]}}, i_inst.i.rs1, i_inst.i.funct3,
                    i_inst.i.imm12[0], i_inst.i.imm12[10:1], 1'b0};

    always_comb begin
        alu_op   = alu_add;
        opb      = rs2_val;
        wr       = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_br    = 1'b0;
        is_jal   = 1'b0;
        case (i_inst.r.opcode)
            op_lui: begin
                alu_op = alu_passb;
                opb    = imm_u;
                wr     = 1'b1;
            end
            op_opimm, op_op: begin
                opb = (i_inst.r.opcode == op_op) ? rs2_val : imm_i;
                wr  = 1'b1;
                case (i_inst.r.funct3)
                    f3_add:  alu_op = (i_inst.r.opcode == op_op && i_inst.r.funct7 == f7_sub)
                                      ? alu_sub : alu_add;
                    f3_xor:  alu_op = alu_xor;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: wr = 1'b0;          // unsupported, no-op
                endcase
            end
            op_load: begin
                opb     = imm_i;                 // address = rs1 + imm
                wr      = 1'b1;
                is_load = 1'b1;
            end
            op_store: begin
                opb      = imm_s;
                is_store = 1'b1;
            end
            op_branch: is_br = 1'b1;
            op_jal: begin
                wr     = 1'b1;
                is_jal = 1'b1;
            end
            default: ;                           // anything else is a no-op
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_sub: alu_y = rs1_val - opb;
            alu_and: alu_y = rs1_val & opb;
            alu_or:  alu_y = rs1_val | opb;
            alu_xor: alu_y = rs1_val ^ opb;
            alu_add: alu_y = rs1_val + opb;
            default: alu_y = opb;                // lui
        endcase
    end

    assign taken = is_jal || (is_br && ((i_inst.r.funct3 == f3_beq && rs1_val == rs2_val) ||
                                        (i_inst.r.funct3 == f3_bne && rs1_val != rs2_val)));
    assign o_flush     = i_valid && !i_stall && taken;  // one pulse per branch
    assign o_target_pc = i_pc + (is_jal ? imm_j : imm_b);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid    <= 1'b0;
            o_is_load  <= 1'b0;
            o_is_store <= 1'b0;
            o_rd_wr    <= 1'b0;
        end else if (!i_stall) begin
            o_valid    <= i_valid;
            o_is_load  <= i_valid && is_load;
            o_is_store <= i_valid && is_store;
            o_rd_wr    <= i_valid && wr && (i_inst.r.rd != '0);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_rd_addr    <= i_inst.r.rd;
            o_result     <= is_jal ? (i_pc + 32'd4) : alu_y;  // link for jal
            o_store_data <= rs2_val;
        end
    end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
    input  logic                  i_clk,
    input  logic [reg_addr_w-1:0] i_rs1_addr,
    input  logic [reg_addr_w-1:0] i_rs2_addr,
    output logic [xlen-1:0]       o_rs1_data,
    output logic [xlen-1:0]       o_rs2_data,
    input  logic                  i_wr_en,
    input  logic [reg_addr_w-1:0] i_rd_addr,
    input  logic [xlen-1:0]       i_rd_data
);

    logic [xlen-1:0] regs [1:31];                // x0 not stored

    always_ff @(posedge i_clk) begin
        if (i_wr_en && i_rd_addr != '0)
            regs[i_rd_addr] <= i_rd_data;
    end

    // async reads, x0 reads zero
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- design/rv_fetch.sv
`timescale 1ns/1ns

module rv_fetch import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_stall,             // mem stage busy
    input  logic            i_flush,             // taken branch/jump
    input  logic [xlen-1:0] i_target_pc,
    output logic            o_if_stb,
    output logic [xlen-1:0] o_if_addr,
    input  logic            i_if_ack,
    input  logic [xlen-1:0] i_rdata,
    output inst_u           o_inst,              // to execute
    output logic [xlen-1:0] o_pc,
    output logic            o_valid
);

    logic            run_q;                      // out of reset, request always on
    logic            drop_q;                     // outstanding word is wrong path
    logic [xlen-1:0] pc_q;                       // address being fetched
    logic [xlen-1:0] tgt_q;                      // redirect held while dropping
    logic            take;

    // word accepted into execute register
    assign take = i_if_ack && !drop_q && !i_stall && !i_flush;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            run_q   <= 1'b0;
            drop_q  <= 1'b0;
            pc_q    <= pc_reset;
            o_valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (i_flush) begin
                o_valid <= 1'b0;
                if (i_if_ack)
                    pc_q <= i_target_pc;         // request just ended, redirect now
                else
                    drop_q <= 1'b1;              // wait for the stale ack
            end else begin
                if (!i_stall)
                    o_valid <= take;
                if (i_if_ack && drop_q) begin
                    drop_q <= 1'b0;
                    pc_q   <= tgt_q;
                end else if (take) begin
                    pc_q <= pc_q + 32'd4;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_flush)
            tgt_q <= i_target_pc;
        if (take) begin
            o_inst <= i_rdata;
            o_pc   <= pc_q;
        end
    end

    assign o_if_stb  = run_q;                    // ack during stall is refetched
    assign o_if_addr = pc_q;                     // held until ack

endmodule

//--- design/rv_bus_arbiter.sv
`timescale 1ns/1ns

module rv_bus_arbiter import rv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_if_stb,            // fetch request
    input  logic [xlen-1:0] i_if_addr,
    output logic            o_if_ack,
    input  logic            i_dm_stb,            // load/store request
    input  logic            i_dm_we,
    input  logic [xlen-1:0] i_dm_addr,
    input  logic [xlen-1:0] i_dm_wdata,
    output logic            o_dm_ack,
    output logic [xlen-1:0] o_rdata,             // shared read data
    output logic            o_bus_stb,
    output logic            o_bus_we,
    output logic [xlen-1:0] o_bus_addr,
    output logic [xlen-1:0] o_bus_wdata,
    input  logic [xlen-1:0] i_bus_rdata,
    input  logic            i_bus_ack
);

    logic [1:0] own_q;                           // locked owner
    logic [1:0] sel;                             // owner this cycle

    always_comb begin
        sel = own_q;
        if (own_q == own_idle) begin             // free bus, data side first
            if (i_dm_stb)
                sel = own_dm;
            else if (i_if_stb)
                sel = own_if;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst)
            own_q <= own_idle;
        else if (i_bus_ack)
            own_q <= own_idle;                   // transfer done, release
        else
            own_q <= sel;                        // lock on accept
    end

    assign o_bus_stb   = (sel != own_idle);
    assign o_bus_we    = (sel == own_dm) && i_dm_we;
    assign o_bus_addr  = (sel == own_dm) ? i_dm_addr : i_if_addr;
    assign o_bus_wdata = (sel == own_dm) ? i_dm_wdata : '0;
    assign o_rdata     = i_bus_rdata;
    assign o_if_ack    = i_bus_ack && (sel == own_if);  // ack only to owner
    assign o_dm_ack    = i_bus_ack && (sel == own_dm);

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;                  // data and address width
    localparam int reg_addr_w = 5;                   // register index width

    localparam logic [xlen-1:0] pc_reset = 32'h0000_0000; // first fetch address

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    localparam logic [2:0] f3_add = 3'b000;          // also addi
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] f7_sub = 7'b0100000;      // add -> sub

    // bus owner encoding for the arbiter
    localparam logic [1:0] own_idle = 2'd0;
    localparam logic [1:0] own_if   = 2'd1;
    localparam logic [1:0] own_dm   = 2'd2;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_passb
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;                                      // register-register view

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;                                      // immediate view, also holds u/j bits

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;                                      // store and branch view

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
    } inst_u;

endpackage
